/* logic/regblk_pkg.sv */
`default_nettype none

package regblk_pkg;

  // Bus widths
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;  // Byte address inside the block
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [1:0]        resp_t;

  // AXI response codes
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Register map
  localparam addr_t OFS_CTRL    = 8'h00;
  localparam addr_t OFS_STATUS  = 8'h04;
  localparam addr_t OFS_IRQ     = 8'h08;
  localparam addr_t OFS_CMD     = 8'h0c;
  localparam addr_t OFS_SCRATCH = 8'h10;

  // Control fields driven to hardware
  typedef struct packed {
    logic [3:0] mode;
    logic       enable;
  } ctrl_t;

  // Register bus request from a port
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t strb;
  } reg_req_t;

  typedef struct packed {
    data_t rdata;
    resp_t resp;
  } reg_rsp_t;

endpackage

`default_nettype wire

/* logic/axil_write_port.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_write_port import regblk_pkg::*; (
  input  logic     clk,
  input  logic     i_rst_n,
  input  logic     i_awvalid,
  input  addr_t    i_awaddr,
  input  logic     i_wvalid,
  input  data_t    i_wdata,
  input  strb_t    i_wstrb,
  input  logic     i_bready,
  input  logic     i_ack,
  input  reg_rsp_t i_rsp,
  output logic     o_awready,
  output logic     o_wready,
  output logic     o_bvalid,
  output resp_t    o_bresp,
  output logic     o_req,
  output reg_req_t o_req_data
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_REQ,
    WR_ACK_DROP,
    WR_RESP
  } wr_state_e;

  wr_state_e state_q;
  logic      addr_hs;

  // AW and W are accepted in the same cycle
  assign addr_hs   = (state_q == WR_IDLE) && i_awvalid && i_wvalid;
  assign o_awready = addr_hs;
  assign o_wready  = addr_hs;
  assign o_req     = (state_q == WR_REQ);
  assign o_bvalid  = (state_q == WR_RESP);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= WR_IDLE;
    end else begin
      case (state_q)
        WR_IDLE: begin
          if (addr_hs) begin
            state_q <= WR_REQ;
          end
        end
        WR_REQ: begin
          if (i_ack) begin
            state_q <= WR_RESP;  // req drops, bvalid rises
          end
        end
        WR_RESP: begin
          if (i_bready) begin
            state_q <= i_ack ? WR_ACK_DROP : WR_IDLE;
          end
        end
        WR_ACK_DROP: begin
          if (!i_ack) begin
            state_q <= WR_IDLE;
          end
        end
        default: state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (addr_hs) begin
      o_req_data.write <= 1'b1;
      o_req_data.addr  <= i_awaddr;
      o_req_data.wdata <= i_wdata;
      o_req_data.strb  <= i_wstrb;
    end
    if (o_req && i_ack) begin
      o_bresp <= i_rsp.resp;
    end
  end

endmodule

`default_nettype wire

/* logic/axil_read_port.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_read_port import regblk_pkg::*; (
  input  logic     clk,
  input  logic     i_rst_n,
  input  logic     i_arvalid,
  input  addr_t    i_araddr,
  input  logic     i_rready,
  input  logic     i_ack,
  input  reg_rsp_t i_rsp,
  output logic     o_arready,
  output logic     o_rvalid,
  output data_t    o_rdata,
  output resp_t    o_rresp,
  output logic     o_req,
  output reg_req_t o_req_data
);

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_REQ,
    RD_ACK_DROP,
    RD_RESP
  } rd_state_e;

  rd_state_e state_q;
  logic      addr_hs;

  assign addr_hs   = (state_q == RD_IDLE) && i_arvalid;
  assign o_arready = addr_hs;
  assign o_req     = (state_q == RD_REQ);
  assign o_rvalid  = (state_q == RD_RESP);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= RD_IDLE;
    end else begin
      case (state_q)
        RD_IDLE:     state_q <= addr_hs ? RD_REQ : RD_IDLE;
        RD_REQ:      state_q <= i_ack ? RD_RESP : RD_REQ;
        RD_RESP: begin
          if (i_rready) begin
            state_q <= i_ack ? RD_ACK_DROP : RD_IDLE;
          end
        end
        RD_ACK_DROP: state_q <= i_ack ? RD_ACK_DROP : RD_IDLE;
        default:     state_q <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (addr_hs) begin
      o_req_data <= '{write: 1'b0, addr: i_araddr, wdata: '0, strb: '0};
    end
    // Read data held until rready
    if (o_req && i_ack) begin
      o_rdata <= i_rsp.rdata;
      o_rresp <= i_rsp.resp;
    end
  end

endmodule

`default_nettype wire

/* logic/reg_bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_bus_arbiter import regblk_pkg::*; (
  input  logic     clk,
  input  logic     i_rst_n,
  input  logic     i_wr_req,
  input  reg_req_t i_wr_req_data,
  input  logic     i_rd_req,
  input  reg_req_t i_rd_req_data,
  input  reg_rsp_t i_map_rsp,
  output logic     o_wr_ack,
  output logic     o_rd_ack,
  output reg_rsp_t o_rsp,
  output logic     o_map_access,
  output reg_req_t o_map_req
);

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_ACCESS,
    ARB_ACK
  } arb_state_e;

  arb_state_e state_q;
  logic       grant_rd_q;  // Current or last grant went to the read port
  logic       granted_req;

  assign granted_req  = grant_rd_q ? i_rd_req : i_wr_req;
  assign o_map_access = (state_q == ARB_ACCESS);
  assign o_map_req    = grant_rd_q ? i_rd_req_data : i_wr_req_data;
  assign o_wr_ack     = (state_q == ARB_ACK) && !grant_rd_q;
  assign o_rd_ack     = (state_q == ARB_ACK) && grant_rd_q;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q    <= ARB_IDLE;
      grant_rd_q <= 1'b0;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (i_wr_req || i_rd_req) begin
            state_q    <= ARB_ACCESS;
            // Under contention the port not served last wins
            grant_rd_q <= i_rd_req && (!i_wr_req || !grant_rd_q);
          end
        end
        ARB_ACCESS: state_q <= ARB_ACK;
        ARB_ACK: begin
          if (!granted_req) begin
            state_q <= ARB_IDLE;  // ack falls one cycle after req
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  // Response captured at the end of the access cycle
  always_ff @(posedge clk) begin
    if (o_map_access) begin
      o_rsp <= i_map_rsp;
    end
  end

endmodule

`default_nettype wire

/* logic/reg_map.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_map import regblk_pkg::*; #(
  parameter data_t DEFAULT_READ_DATA = 32'hdead_beef,
  parameter int    IRQ_W             = 4
) (
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_access,
  input  reg_req_t         i_req,
  input  logic [7:0]       i_hw_status,
  input  logic [IRQ_W-1:0] i_irq_set,
  output reg_rsp_t         o_rsp,
  output ctrl_t            o_ctrl,
  output logic [IRQ_W-1:0] o_irq_pending,
  output logic [IRQ_W-1:0] o_cmd_trigger
);

  ctrl_t            ctrl_q;
  logic [IRQ_W-1:0] irq_q;
  logic [IRQ_W-1:0] trig_q;
  data_t            scratch_q;
  data_t            ctrl_word;
  data_t            ctrl_next;
  logic             sel_ctrl;
  logic             sel_irq;
  logic             sel_cmd;
  logic             sel_scratch;
  logic             wr_en;
  logic [IRQ_W-1:0] wr_flags;  // Byte 0 write bits at flag width
  logic [IRQ_W-1:0] irq_clr;

  // Replace only the byte lanes selected by strb
  function automatic data_t merge_bytes(data_t old_val, data_t new_val, strb_t strb);
    data_t result;
    result = old_val;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return result;
  endfunction

  assign sel_ctrl    = (i_req.addr == OFS_CTRL);
  assign sel_irq     = (i_req.addr == OFS_IRQ);
  assign sel_cmd     = (i_req.addr == OFS_CMD);
  assign sel_scratch = (i_req.addr == OFS_SCRATCH);

  assign wr_en    = i_access && i_req.write;
  assign wr_flags = i_req.strb[0] ? i_req.wdata[IRQ_W-1:0] : '0;
  assign irq_clr  = (wr_en && sel_irq) ? wr_flags : '0;

  // CTRL as seen on the bus, mode in 3:0 and enable in bit 8
  always_comb begin
    ctrl_word       = '0;
    ctrl_word[3:0]  = ctrl_q.mode;
    ctrl_word[8]    = ctrl_q.enable;
    ctrl_next       = merge_bytes(ctrl_word, i_req.wdata, i_req.strb);
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ctrl_q    <= '0;
      irq_q     <= '0;
      trig_q    <= '0;
      scratch_q <= '0;
    end else begin
      if (wr_en && sel_ctrl) begin
        ctrl_q.mode   <= ctrl_next[3:0];
        ctrl_q.enable <= ctrl_next[8];
      end
      if (wr_en && sel_scratch) begin
        scratch_q <= merge_bytes(scratch_q, i_req.wdata, i_req.strb);
      end
      // Hardware set beats a same-cycle W1C
      irq_q  <= (irq_q & ~irq_clr) | i_irq_set;
      trig_q <= (wr_en && sel_cmd) ? wr_flags : '0;  // One-cycle pulse
    end
  end

  // Read data and response, combinational on the request
  always_comb begin
    o_rsp.rdata = '0;
    o_rsp.resp  = RESP_OKAY;
    case (i_req.addr)
      OFS_CTRL: begin
        o_rsp.rdata = ctrl_word;
      end
      OFS_STATUS: begin
        o_rsp.rdata[7:0] = i_hw_status;  // Writes fall through with OKAY
      end
      OFS_IRQ: begin
        o_rsp.rdata[IRQ_W-1:0] = irq_q;
      end
      OFS_CMD: begin
        o_rsp.rdata = '0;
      end
      OFS_SCRATCH: begin
        o_rsp.rdata = scratch_q;
      end
      default: begin
        o_rsp.rdata = DEFAULT_READ_DATA;
        o_rsp.resp  = RESP_SLVERR;
      end
    endcase
  end

  assign o_ctrl        = ctrl_q;
  assign o_irq_pending = irq_q;
  assign o_cmd_trigger = trig_q;

endmodule

`default_nettype wire

/* logic/regblk_top.sv */
`timescale 1ns/1ps
`default_nettype none

module regblk_top import regblk_pkg::*; #(
  parameter data_t DEFAULT_READ_DATA = 32'hdead_beef,
  parameter int    IRQ_W             = 4
) (
  input  logic             clk,
  input  logic             i_rst_n,
  // AXI4-Lite slave
  input  logic             i_awvalid,
  output logic             o_awready,
  input  addr_t            i_awaddr,
  input  logic             i_wvalid,
  output logic             o_wready,
  input  data_t            i_wdata,
  input  strb_t            i_wstrb,
  output logic             o_bvalid,
  input  logic             i_bready,
  output resp_t            o_bresp,
  input  logic             i_arvalid,
  output logic             o_arready,
  input  addr_t            i_araddr,
  output logic             o_rvalid,
  input  logic             i_rready,
  output data_t            o_rdata,
  output resp_t            o_rresp,
  // Hardware side
  input  logic [7:0]       i_hw_status,
  input  logic [IRQ_W-1:0] i_irq_set,
  output ctrl_t            o_ctrl,
  output logic [IRQ_W-1:0] o_irq_pending,
  output logic [IRQ_W-1:0] o_cmd_trigger
);

  logic     wr_req;
  logic     wr_ack;
  reg_req_t wr_req_data;
  logic     rd_req;
  logic     rd_ack;
  reg_req_t rd_req_data;
  reg_rsp_t bus_rsp;  // Shared by both ports, qualified by ack
  logic     map_access;
  reg_req_t map_req;
  reg_rsp_t map_rsp;

  axil_write_port axil_write_port_inst (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_awvalid  (i_awvalid),
    .i_awaddr   (i_awaddr),
    .i_wvalid   (i_wvalid),
    .i_wdata    (i_wdata),
    .i_wstrb    (i_wstrb),
    .i_bready   (i_bready),
    .i_ack      (wr_ack),
    .i_rsp      (bus_rsp),
    .o_awready  (o_awready),
    .o_wready   (o_wready),
    .o_bvalid   (o_bvalid),
    .o_bresp    (o_bresp),
    .o_req      (wr_req),
    .o_req_data (wr_req_data)
  );

  axil_read_port axil_read_port_inst (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_arvalid  (i_arvalid),
    .i_araddr   (i_araddr),
    .i_rready   (i_rready),
    .i_ack      (rd_ack),
    .i_rsp      (bus_rsp),
    .o_arready  (o_arready),
    .o_rvalid   (o_rvalid),
    .o_rdata    (o_rdata),
    .o_rresp    (o_rresp),
    .o_req      (rd_req),
    .o_req_data (rd_req_data)
  );

  reg_bus_arbiter reg_bus_arbiter_inst (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_wr_req      (wr_req),
    .i_wr_req_data (wr_req_data),
    .i_rd_req      (rd_req),
    .i_rd_req_data (rd_req_data),
    .i_map_rsp     (map_rsp),
    .o_wr_ack      (wr_ack),
    .o_rd_ack      (rd_ack),
    .o_rsp         (bus_rsp),
    .o_map_access  (map_access),
    .o_map_req     (map_req)
  );

  reg_map #(
    .DEFAULT_READ_DATA (DEFAULT_READ_DATA),
    .IRQ_W             (IRQ_W)
  ) reg_map_inst (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_access      (map_access),
    .i_req         (map_req),
    .i_hw_status   (i_hw_status),
    .i_irq_set     (i_irq_set),
    .o_rsp         (map_rsp),
    .o_ctrl        (o_ctrl),
    .o_irq_pending (o_irq_pending),
    .o_cmd_trigger (o_cmd_trigger)
  );

endmodule

`default_nettype wire

/* verif/regblk_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module regblk_asserts import regblk_pkg::*; (
  input logic     clk,
  input logic     i_rst_n,
  input logic     i_wr_req,
  input reg_req_t i_wr_req_data,
  input logic     i_rd_req,
  input reg_req_t i_rd_req_data,
  input logic     o_wr_ack,
  input logic     o_rd_ack,
  input reg_rsp_t o_rsp
);

  // Req stays up and its payload stays put until ack
  assert property (@(posedge clk) disable iff (!i_rst_n)
    i_wr_req && !o_wr_ack |=> i_wr_req && $stable(i_wr_req_data))
    else $error("write req dropped or changed before ack");
  assert property (@(posedge clk) disable iff (!i_rst_n)
    i_rd_req && !o_rd_ack |=> i_rd_req && $stable(i_rd_req_data))
    else $error("read req dropped or changed before ack");

  // Ack only answers a pending req
  assert property (@(posedge clk) disable iff (!i_rst_n) $rose(o_wr_ack) |-> i_wr_req)
    else $error("write ack rose without a write req");
  assert property (@(posedge clk) disable iff (!i_rst_n) $rose(o_rd_ack) |-> i_rd_req)
    else $error("read ack rose without a read req");
  assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_wr_ack && i_wr_req) || (o_rd_ack && i_rd_req) |=> o_wr_ack || o_rd_ack)
    else $error("ack fell while req was still high");
  assert property (@(posedge clk) disable iff (!i_rst_n)
    o_wr_ack && !i_wr_req |=> !i_wr_req)
    else $error("new write req before ack fell");

  // Response held for the whole ack phase
  assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_wr_ack || o_rd_ack) |=> !(o_wr_ack || o_rd_ack) || $stable(o_rsp))
    else $error("response changed while ack high");

endmodule

`default_nettype wire

/* verif/regblk_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module regblk_checker import regblk_pkg::*; #(
  parameter data_t DEFAULT_READ_DATA = 32'hdead_beef,
  parameter int    IRQ_W             = 4
) (
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_awvalid,
  input  logic             i_awready,
  input  addr_t            i_awaddr,
  input  data_t            i_wdata,
  input  strb_t            i_wstrb,
  input  logic             i_bvalid,
  input  logic             i_bready,
  input  resp_t            i_bresp,
  input  logic             i_arvalid,
  input  logic             i_arready,
  input  addr_t            i_araddr,
  input  logic             i_rvalid,
  input  logic             i_rready,
  input  data_t            i_rdata,
  input  resp_t            i_rresp,
  input  logic [7:0]       i_hw_status,
  input  logic [IRQ_W-1:0] i_irq_set,
  input  ctrl_t            i_ctrl,
  input  logic [IRQ_W-1:0] i_irq_pending,
  input  logic [IRQ_W-1:0] i_cmd_trigger,
  input  data_t            i_exp_rdata,  // Read data from the stimulus table
  output int               o_err_count,
  output int               o_check_count
);

  ctrl_t            m_ctrl;
  logic [IRQ_W-1:0] m_irq;
  data_t            m_scratch;
  logic             wr_busy;
  addr_t            wr_addr;
  data_t            wr_data;
  strb_t            wr_strb;
  addr_t            rd_addr;
  int               trig_cnt;
  logic [IRQ_W-1:0] trig_val;
  logic             bvalid_q;
  logic [IRQ_W-1:0] set_d1;  // irq set one edge back
  logic [IRQ_W-1:0] set_d2;

  function automatic data_t model_read(addr_t addr);
    data_t val;
    val = '0;
    if (addr == OFS_CTRL) begin
      val[3:0] = m_ctrl.mode;
      val[8]   = m_ctrl.enable;
    end else if (addr == OFS_STATUS) begin
      val[7:0] = i_hw_status;
    end else if (addr == OFS_IRQ) begin
      val[IRQ_W-1:0] = m_irq;
    end else if (addr == OFS_SCRATCH) begin
      val = m_scratch;
    end else if (addr != OFS_CMD) begin
      val = DEFAULT_READ_DATA;
    end
    return val;
  endfunction

  function automatic resp_t model_resp(addr_t addr);
    if (addr == OFS_CTRL || addr == OFS_STATUS || addr == OFS_IRQ ||
        addr == OFS_CMD || addr == OFS_SCRATCH) begin
      return RESP_OKAY;
    end
    return RESP_SLVERR;
  endfunction

  function automatic data_t lane_mask(strb_t strb);
    data_t mask;
    for (int i = 0; i < STRB_W; i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    return mask;
  endfunction

  task automatic compare(input string name, input data_t exp, input data_t got);
    o_check_count++;
    if (exp !== got) begin
      o_err_count++;
      $display("error at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // Model write, applied when the b handshake completes
  task automatic apply_write();
    data_t mask;
    data_t word;
    mask = lane_mask(wr_strb);
    if (wr_addr == OFS_CTRL) begin
      word = model_read(OFS_CTRL);
      word = (word & ~mask) | (wr_data & mask);
      m_ctrl.mode   = word[3:0];
      m_ctrl.enable = word[8];
    end else if (wr_addr == OFS_SCRATCH) begin
      m_scratch = (m_scratch & ~mask) | (wr_data & mask);
    end
  endtask

  always @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      m_ctrl        = '0;
      m_irq         = '0;
      m_scratch     = '0;
      wr_busy       = 1'b0;
      trig_cnt      = 0;
      trig_val      = '0;
      bvalid_q      = 1'b0;
      set_d1        = '0;
      set_d2        = '0;
      o_err_count   = 0;
      o_check_count = 0;
    end else begin
      if (!wr_busy) begin
        compare("o_ctrl", data_t'(m_ctrl), data_t'(i_ctrl));
        compare("o_irq_pending", data_t'(m_irq), data_t'(i_irq_pending));
        compare("o_cmd_trigger", '0, data_t'(i_cmd_trigger));
      end else if (i_cmd_trigger != '0) begin
        trig_cnt++;
        trig_val = i_cmd_trigger;
      end
      if (i_awvalid && i_awready) begin
        wr_busy  = 1'b1;
        wr_addr  = i_awaddr;
        wr_data  = i_wdata;
        wr_strb  = i_wstrb;
        trig_cnt = 0;
      end
      if (i_arvalid && i_arready) begin
        rd_addr = i_araddr;
      end
      if (i_rvalid && i_rready) begin
        compare("o_rdata", model_read(rd_addr), i_rdata);
        compare("o_rdata vs table", i_exp_rdata, i_rdata);
        compare("o_rresp", data_t'(model_resp(rd_addr)), data_t'(i_rresp));
      end
      if (i_bvalid && i_bready) begin
        compare("o_bresp", data_t'(model_resp(wr_addr)), data_t'(i_bresp));
        if (wr_addr == OFS_CMD && wr_strb[0] && wr_data[IRQ_W-1:0] != '0) begin
          compare("o_cmd_trigger pulse count", 1, trig_cnt);
          compare("o_cmd_trigger", data_t'(wr_data[IRQ_W-1:0]), data_t'(trig_val));
        end else begin
          compare("o_cmd_trigger pulse count", 0, trig_cnt);
        end
        apply_write();
        wr_busy = 1'b0;
      end
      // W1C took effect where ack rose, two edges before bvalid is first seen
      if (i_bvalid && !bvalid_q && wr_addr == OFS_IRQ && wr_strb[0]) begin
        m_irq = (m_irq & ~wr_data[IRQ_W-1:0]) | set_d2 | set_d1;
      end
      m_irq    = m_irq | i_irq_set;  // Sets from the clear edge on survive
      set_d2   = set_d1;
      set_d1   = i_irq_set;
      bvalid_q = i_bvalid;
    end
  end

endmodule

`default_nettype wire

/* verif/tb_regblk.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_regblk import regblk_pkg::*; ();

  localparam data_t DEFAULT_READ_DATA = 32'hdead_beef;
  localparam int    IRQ_W             = 4;
  localparam int    HS_LIMIT          = 40;  // Cycles allowed per handshake
  localparam logic [1:0] OP_WR   = 2'd0;
  localparam logic [1:0] OP_RD   = 2'd1;
  localparam logic [1:0] OP_BOTH = 2'd2;

  typedef struct packed {
    logic [1:0]       op;
    addr_t            addr;
    data_t            data;
    strb_t            strb;
    addr_t            rd_addr;
    logic [7:0]       hw_status;
    logic [IRQ_W-1:0] irq_set;
    data_t            exp_rdata;
  } row_t;

  logic             clk;
  logic             rst_n;
  logic             awvalid;
  logic             awready;
  addr_t            awaddr;
  logic             wvalid;
  logic             wready;
  data_t            wdata;
  strb_t            wstrb;
  logic             bvalid;
  logic             bready;
  resp_t            bresp;
  logic             arvalid;
  logic             arready;
  addr_t            araddr;
  logic             rvalid;
  logic             rready;
  data_t            rdata;
  resp_t            rresp;
  logic [7:0]       hw_status;
  logic [IRQ_W-1:0] irq_set;
  ctrl_t            ctrl;
  logic [IRQ_W-1:0] irq_pending;
  logic [IRQ_W-1:0] cmd_trigger;
  data_t            exp_rdata;
  int               err_count;
  int               check_count;
  int               tb_errors;
  int               seed;
  int               wr_delay;
  int               rd_delay;
  row_t             rows[$];

  regblk_top #(
    .DEFAULT_READ_DATA (DEFAULT_READ_DATA),
    .IRQ_W             (IRQ_W)
  ) regblk_top_inst (
    .clk           (clk),
    .i_rst_n       (rst_n),
    .i_awvalid     (awvalid),
    .o_awready     (awready),
    .i_awaddr      (awaddr),
    .i_wvalid      (wvalid),
    .o_wready      (wready),
    .i_wdata       (wdata),
    .i_wstrb       (wstrb),
    .o_bvalid      (bvalid),
    .i_bready      (bready),
    .o_bresp       (bresp),
    .i_arvalid     (arvalid),
    .o_arready     (arready),
    .i_araddr      (araddr),
    .o_rvalid      (rvalid),
    .i_rready      (rready),
    .o_rdata       (rdata),
    .o_rresp       (rresp),
    .i_hw_status   (hw_status),
    .i_irq_set     (irq_set),
    .o_ctrl        (ctrl),
    .o_irq_pending (irq_pending),
    .o_cmd_trigger (cmd_trigger)
  );

  regblk_checker #(
    .DEFAULT_READ_DATA (DEFAULT_READ_DATA),
    .IRQ_W             (IRQ_W)
  ) regblk_checker_inst (
    .clk           (clk),
    .i_rst_n       (rst_n),
    .i_awvalid     (awvalid),
    .i_awready     (awready),
    .i_awaddr      (awaddr),
    .i_wdata       (wdata),
    .i_wstrb       (wstrb),
    .i_bvalid      (bvalid),
    .i_bready      (bready),
    .i_bresp       (bresp),
    .i_arvalid     (arvalid),
    .i_arready     (arready),
    .i_araddr      (araddr),
    .i_rvalid      (rvalid),
    .i_rready      (rready),
    .i_rdata       (rdata),
    .i_rresp       (rresp),
    .i_hw_status   (hw_status),
    .i_irq_set     (irq_set),
    .i_ctrl        (ctrl),
    .i_irq_pending (irq_pending),
    .i_cmd_trigger (cmd_trigger),
    .i_exp_rdata   (exp_rdata),
    .o_err_count   (err_count),
    .o_check_count (check_count)
  );

  bind reg_bus_arbiter regblk_asserts regblk_asserts_inst (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_wr_req      (i_wr_req),
    .i_wr_req_data (i_wr_req_data),
    .i_rd_req      (i_rd_req),
    .i_rd_req_data (i_rd_req_data),
    .o_wr_ack      (o_wr_ack),
    .o_rd_ack      (o_rd_ack),
    .o_rsp         (o_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic add_row(input logic [1:0] op, input addr_t addr, input data_t data,
                         input strb_t strb, input addr_t rd_addr, input logic [7:0] hw,
                         input logic [IRQ_W-1:0] irq, input data_t exp);
    rows.push_back('{op, addr, data, strb, rd_addr, hw, irq, exp});
  endtask

  // One AXI write, called 1 ns after a rising edge
  task automatic run_write(input row_t r, input int delay);
    int waited;
    awvalid = 1'b1;
    awaddr  = r.addr;
    wvalid  = 1'b1;
    wdata   = r.data;
    wstrb   = r.strb;
    waited  = 0;
    @(negedge clk);
    while (!(awready && wready) && waited < HS_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!(awready && wready)) begin
      tb_errors++;
      $display("write to %h was never accepted at %0t", r.addr, $time);
    end
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    irq_set = r.irq_set;  // Two cycles, the second one is the register access
    repeat (2) @(posedge clk);
    #1 irq_set = '0;
    waited  = 0;
    @(negedge clk);
    while (!bvalid && waited < HS_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!bvalid) begin
      tb_errors++;
      $display("no write response for %h at %0t", r.addr, $time);
    end else begin
      repeat (delay) @(posedge clk);  // Back-pressure on b
      @(posedge clk);
      #1 bready = 1'b1;
      @(posedge clk);
      #1 bready = 1'b0;
    end
  endtask

  task automatic run_read(input row_t r, input int delay);
    int waited;
    arvalid = 1'b1;
    araddr  = r.rd_addr;
    waited  = 0;
    @(negedge clk);
    while (!arready && waited < HS_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!arready) begin
      tb_errors++;
      $display("read of %h was never accepted at %0t", r.rd_addr, $time);
    end
    @(posedge clk);
    #1 arvalid = 1'b0;
    waited = 0;
    @(negedge clk);
    while (!rvalid && waited < HS_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!rvalid) begin
      tb_errors++;
      $display("no read response for %h at %0t", r.rd_addr, $time);
    end else begin
      repeat (delay) @(posedge clk);
      @(posedge clk);
      #1 rready = 1'b1;
      @(posedge clk);
      #1 rready = 1'b0;
    end
  endtask

  initial begin
    #1;
    repeat (rows.size() * 50 + 20) @(posedge clk);
    $display("timeout: the test rows did not finish in time");
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    seed      = 32'hadd;
    tb_errors = 0;
    rst_n     = 1'b0;
    awvalid   = 1'b0;
    awaddr    = '0;
    wvalid    = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    bready    = 1'b0;
    arvalid   = 1'b0;
    araddr    = '0;
    rready    = 1'b0;
    hw_status = '0;
    irq_set   = '0;
    exp_rdata = '0;

    // op, wr addr, wr data, strb, rd addr, hw status, irq set, expected read
    add_row(OP_RD,   8'h00, 32'h0,         4'h0, 8'h00, 8'h00, 4'h0, 32'h0);
    add_row(OP_RD,   8'h00, 32'h0,         4'h0, 8'h08, 8'h00, 4'h0, 32'h0);
    add_row(OP_RD,   8'h00, 32'h0,         4'h0, 8'h10, 8'h00, 4'h0, 32'h0);
    add_row(OP_WR,   8'h00, 32'h0000_0105, 4'hf, 8'h00, 8'h00, 4'h0, 32'h0);
    add_row(OP_RD,   8'h00, 32'h0,         4'h0, 8'h00, 8'h00, 4'h0, 32'h0000_0105);
    add_row(OP_WR,   8'h00, 32'hffff_ff0a, 4'h1, 8'h00, 8'h00, 4'h0, 32'h0);
    add_row(OP_RD,   8'h00, 32'h0,         4'h0, 8'h00, 8'h00, 4'h0, 32'h0000_010a);
    add_row(OP_WR,   8'h00, 32'h0,         4'h2, 8'h00, 8'h00, 4'h0, 32'h0);
    add_row(OP_RD,   8'h00, 32'h0,         4'h0, 8'h00, 8'h00, 4'h0, 32'h0000_000a);
    add_row(OP_WR,   8'h10, 32'h1234_5678, 4'hf, 8'h00, 8'h00, 4'h0, 32'h0);
    add_row(OP_WR,   8'h10, 32'haabb_ccdd, 4'ha, 8'h00, 8'h00, 4'h0, 32'h0);
    add_row(OP_RD,   8'h00, 32'h0,         4'h0, 8'h10, 8'h00, 4'h0, 32'haa34_cc78);
    add_row(OP_RD,   8'h00, 32'h0,         4'h0, 8'h04, 8'h5a, 4'h0, 32'h0000_005a);
    add_row(OP_WR,   8'h04, 32'hffff_ffff, 4'hf, 8'h00, 8'h5a, 4'h0, 32'h0);
    add_row(OP_RD,   8'h00, 32'h0,         4'h0, 8'h04, 8'hc3, 4'h0, 32'h0000_00c3);
    add_row(OP_RD,   8'h00, 32'h0,         4'h0, 8'h08, 8'h00, 4'h5, 32'h0000_0005);
    add_row(OP_WR,   8'h08, 32'h0000_0001, 4'h1, 8'h00, 8'h00, 4'h0, 32'h0);
    add_row(OP_RD,   8'h00, 32'h0,         4'h0, 8'h08, 8'h00, 4'h0, 32'h0000_0004);
    add_row(OP_WR,   8'h08, 32'h0000_000f, 4'h1, 8'h00, 8'h00, 4'h4, 32'h0);
    add_row(OP_RD,   8'h00, 32'h0,         4'h0, 8'h08, 8'h00, 4'h0, 32'h0000_0004);
    add_row(OP_WR,   8'h08, 32'h0000_000f, 4'h1, 8'h00, 8'h00, 4'h0, 32'h0);
    add_row(OP_RD,   8'h00, 32'h0,         4'h0, 8'h08, 8'h00, 4'h0, 32'h0);
    add_row(OP_WR,   8'h0c, 32'h0000_0009, 4'h1, 8'h00, 8'h00, 4'h0, 32'h0);
    add_row(OP_RD,   8'h00, 32'h0,         4'h0, 8'h0c, 8'h00, 4'h0, 32'h0);
    add_row(OP_WR,   8'h20, 32'h0000_0001, 4'hf, 8'h00, 8'h00, 4'h0, 32'h0);
    add_row(OP_RD,   8'h00, 32'h0,         4'h0, 8'h20, 8'h00, 4'h0, 32'hdead_beef);
    add_row(OP_BOTH, 8'h10, 32'h0bad_f00d, 4'hf, 8'h14, 8'h00, 4'h0, 32'hdead_beef);
    add_row(OP_BOTH, 8'h0c, 32'h0000_0006, 4'h1, 8'h00, 8'h00, 4'h0, 32'h0000_000a);
    add_row(OP_RD,   8'h00, 32'h0,         4'h0, 8'h10, 8'h00, 4'h0, 32'h0bad_f00d);
    add_row(OP_BOTH, 8'h00, 32'h0000_0103, 4'h3, 8'h04, 8'h77, 4'h0, 32'h0000_0077);
    add_row(OP_RD,   8'h00, 32'h0,         4'h0, 8'h00, 8'h00, 4'h0, 32'h0000_0103);

    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (2) @(posedge clk);

    foreach (rows[i]) begin
      wr_delay = $random(seed) & 3;
      rd_delay = $random(seed) & 3;
      @(posedge clk);
      #1;
      hw_status = rows[i].hw_status;
      // Read rows hold the set through the row, writes pulse it themselves
      irq_set   = (rows[i].op == OP_RD) ? rows[i].irq_set : '0;
      exp_rdata = rows[i].exp_rdata;
      case (rows[i].op)
        OP_WR: run_write(rows[i], wr_delay);
        OP_RD: run_read(rows[i], rd_delay);
        default: begin
          fork
            run_write(rows[i], wr_delay);
            run_read(rows[i], rd_delay);
          join
        end
      endcase
      @(posedge clk);
      #1 irq_set = '0;
      repeat (2) @(posedge clk);
    end

    repeat (4) @(posedge clk);
    $display("checks: %0d, checker errors: %0d, testbench errors: %0d",
             check_count, err_count, tb_errors);
    if (err_count == 0 && tb_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
logic/regblk_pkg.sv
logic/axil_write_port.sv
logic/axil_read_port.sv
logic/reg_bus_arbiter.sv
logic/reg_map.sv
logic/regblk_top.sv
verif/regblk_asserts.sv
verif/regblk_checker.sv
verif/tb_regblk.sv

/* Makefile */
# Verilator build and run for the register block testbench

VERILATOR ?= verilator
TOP       ?= tb_regblk
RTL_TOP   ?= regblk_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
